/* design/agc_loop_pkg.sv */
`default_nettype none

package agc_loop_pkg;

    //////////////////////////////////////////////////
    // Bus and value types

    typedef logic [7:0]         wb_addr_t;    // Byte address
    typedef logic [31:0]        wb_data_t;
    typedef logic [16:0]        agc_scale_t;  // Unsigned gain
    typedef logic signed [15:0] agc_offset_t;

    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t adr;
        wb_data_t dat;
    } wb_req_s;

    typedef struct packed {
        logic     ack;
        wb_data_t dat;
    } wb_rsp_s;

    // Last word first, so status word 0 lands in the low bits
    typedef struct packed {
        wb_data_t offset;     // Word 5
        wb_data_t scale;      // Word 4
        wb_data_t under_cnt;  // Word 3
        wb_data_t over_cnt;   // Word 2
        wb_data_t ms;         // Word 1, mean square
        wb_data_t ctrl;       // Word 0, control/status
    } agc_info_s;

    localparam int INFO_WORDS  = 6;
    localparam int WORD_SCALE  = 4;
    localparam int WORD_OFFSET = 5;

    typedef wb_data_t [INFO_WORDS-1:0] info_words_t;  // Indexable view of agc_info_s

    //////////////////////////////////////////////////
    // Loop tuning

    localparam int unsigned TIMESCALE_RED_BITS = 4;
    localparam int unsigned MS_SHIFT           = 17 - TIMESCALE_RED_BITS;
    localparam int unsigned TARGET_RMS_SQ      = 16;
    localparam int unsigned RMS_SQ_ERR         = 0;
    localparam int unsigned OFFSET_ERR         = 5;   // Allowed over/under imbalance

    localparam agc_scale_t  SCALE_DELTA  = 17'd30;
    localparam agc_offset_t OFFSET_DELTA = 16'sd25;
    localparam agc_scale_t  SCALE_MIN    = 17'd300;     // Scale held at or below this
    localparam agc_scale_t  SCALE_MAX    = 17'd130000;  // and at or above this
    localparam agc_scale_t  START_SCALE  = 17'd1800;
    localparam agc_offset_t START_OFFSET = 16'sd0;

    localparam int unsigned BOOT_DELAY = 31;

    //////////////////////////////////////////////////
    // Downstream register map and commands

    localparam wb_addr_t ADDR_CTRL   = 8'h00;
    localparam wb_addr_t ADDR_SCALE  = 8'h10;
    localparam wb_addr_t ADDR_OFFSET = 8'h14;

    localparam wb_data_t CMD_START = 32'h0000_0001;
    localparam wb_data_t CMD_RESET = 32'h0000_0004;
    localparam wb_data_t CMD_LOAD  = 32'h0000_0300;
    localparam wb_data_t CMD_APPLY = 32'h0000_0400;

    localparam int unsigned STATUS_DONE_BIT = 1;

    typedef enum logic [3:0] {
        SEQ_BOOT,
        SEQ_WR_SCALE,
        SEQ_WR_OFFSET,
        SEQ_LOAD,
        SEQ_APPLY,
        SEQ_RESET,
        SEQ_START,
        SEQ_POLL,
        SEQ_READ
    } seq_state_e;

    typedef enum logic [1:0] {
        TGT_IDLE,
        TGT_WRITE,
        TGT_READ,
        TGT_ACK
    } tgt_state_e;

    typedef enum logic {
        XFER_IDLE,
        XFER_BUSY
    } xfer_state_e;

endpackage

`default_nettype wire

/* design/agc_bus_master.sv */
`default_nettype none

module agc_bus_master (
    input  logic                   wb_clk_i,
    input  logic                   rst_i,
    input  logic                   start_i,
    input  agc_loop_pkg::wb_addr_t adr_i,
    input  agc_loop_pkg::wb_data_t dat_i,
    input  logic                   we_i,
    output logic                   done_o,
    output agc_loop_pkg::wb_data_t rdata_o,
    output agc_loop_pkg::wb_req_s  req_o,
    input  agc_loop_pkg::wb_rsp_s  rsp_i
);
    import agc_loop_pkg::*;

    xfer_state_e state_q;
    wb_req_s     req_q;    // Drives the bus directly
    wb_data_t    rdata_q;
    logic        done_q;
    logic        ack_seen;

    assign ack_seen = (state_q == XFER_BUSY) && rsp_i.ack;

    //////////////////////////////////////////////////
    // One transfer at a time, held until ack

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            state_q <= XFER_IDLE;
            req_q   <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                XFER_IDLE: begin
                    if (start_i) begin
                        req_q.cyc <= 1'b1;
                        req_q.stb <= 1'b1;
                        req_q.we  <= we_i;
                        req_q.adr <= adr_i;
                        req_q.dat <= dat_i;
                        state_q   <= XFER_BUSY;
                    end
                end
                XFER_BUSY: begin
                    if (rsp_i.ack) begin
                        req_q   <= '0;     // Whole bus drops with cyc
                        done_q  <= 1'b1;
                        state_q <= XFER_IDLE;
                    end
                end
                default: state_q <= XFER_IDLE;
            endcase
        end
    end

    // Read data captured on the ack
    always_ff @(posedge wb_clk_i) begin
        if (ack_seen) begin
            rdata_q <= rsp_i.dat;
        end
    end

    assign req_o   = req_q;
    assign done_o  = done_q;   // Same cycle as the drop of cyc
    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* design/agc_gain_calc.sv */
`default_nettype none

module agc_gain_calc (
    input  agc_loop_pkg::agc_info_s   info_i,
    output agc_loop_pkg::agc_scale_t  scale_o,
    output agc_loop_pkg::agc_offset_t offset_o
);
    import agc_loop_pkg::*;

    wb_data_t    ms_shifted;
    agc_scale_t  cur_scale;
    agc_offset_t cur_offset;
    logic [32:0] over_limit;   // Under-count plus margin
    logic [32:0] under_limit;  // Over-count plus margin

    assign ms_shifted = info_i.ms >> MS_SHIFT;
    assign cur_scale  = info_i.scale[16:0];
    assign cur_offset = info_i.offset[15:0];

    // One extra bit so a large count plus margin cannot wrap
    assign over_limit  = {1'b0, info_i.under_cnt} + 33'(OFFSET_ERR);
    assign under_limit = {1'b0, info_i.over_cnt} + 33'(OFFSET_ERR);

    //////////////////////////////////////////////////
    // Scale steps toward the target mean square

    always_comb begin
        scale_o = cur_scale;
        if (ms_shifted > TARGET_RMS_SQ + RMS_SQ_ERR) begin
            if (cur_scale > SCALE_MIN) begin
                scale_o = cur_scale - SCALE_DELTA;  // Too loud
            end
        end else if (ms_shifted < TARGET_RMS_SQ - RMS_SQ_ERR) begin
            if (cur_scale < SCALE_MAX) begin
                scale_o = cur_scale + SCALE_DELTA;  // Too quiet
            end
        end
    end

    //////////////////////////////////////////////////
    // Offset balances over and under counts

    always_comb begin
        offset_o = cur_offset;
        if ({1'b0, info_i.over_cnt} > over_limit) begin
            offset_o = cur_offset - OFFSET_DELTA;   // 16 bit, wraps
        end else if ({1'b0, info_i.under_cnt} > under_limit) begin
            offset_o = cur_offset + OFFSET_DELTA;
        end
    end

endmodule

`default_nettype wire

/* design/agc_loop_sequencer.sv */
`default_nettype none

module agc_loop_sequencer (
    input  logic                      wb_clk_i,
    input  logic                      rst_i,
    output logic                      start_o,
    output agc_loop_pkg::wb_addr_t    adr_o,
    output agc_loop_pkg::wb_data_t    dat_o,
    output logic                      we_o,
    input  logic                      done_i,
    input  agc_loop_pkg::wb_data_t    rdata_i,
    input  agc_loop_pkg::agc_scale_t  next_scale_i,
    input  agc_loop_pkg::agc_offset_t next_offset_i,
    output agc_loop_pkg::agc_info_s   info_o
);
    import agc_loop_pkg::*;

    seq_state_e  state_q;
    logic [4:0]  boot_cnt_q;
    logic [2:0]  read_idx_q;   // Status word being read, INFO_WORDS when all are in
    logic        busy_q;       // A transfer for this step is in flight
    info_words_t info_q;
    agc_scale_t  scale_q;      // Values for the next write pass
    agc_offset_t offset_q;
    wb_data_t    scale_word;
    wb_data_t    offset_word;
    logic        calc_step;

    assign scale_word  = {15'b0, scale_q};
    assign offset_word = {{16{offset_q[15]}}, offset_q};
    assign calc_step   = (state_q == SEQ_READ) && (read_idx_q == 3'(INFO_WORDS));

    // Every step except boot and the calculation cycle issues one transfer
    assign start_o = !busy_q && (state_q != SEQ_BOOT) && !calc_step;

    //////////////////////////////////////////////////
    // Transfer for the current step

    always_comb begin
        adr_o = ADDR_CTRL;
        dat_o = '0;
        we_o  = 1'b1;
        case (state_q)
            SEQ_WR_SCALE: begin
                adr_o = ADDR_SCALE;
                dat_o = scale_word;
            end
            SEQ_WR_OFFSET: begin
                adr_o = ADDR_OFFSET;
                dat_o = offset_word;
            end
            SEQ_LOAD:  dat_o = CMD_LOAD;
            SEQ_APPLY: dat_o = CMD_APPLY;
            SEQ_RESET: dat_o = CMD_RESET;
            SEQ_START: dat_o = CMD_START;
            SEQ_POLL:  we_o  = 1'b0;        // Status read
            SEQ_READ: begin
                adr_o = wb_addr_t'({read_idx_q, 2'b00});
                we_o  = 1'b0;
            end
            default: we_o = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////
    // Control loop

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            state_q    <= SEQ_BOOT;
            boot_cnt_q <= '0;
            read_idx_q <= '0;
            busy_q     <= 1'b0;
            info_q     <= '0;
            scale_q    <= START_SCALE;
            offset_q   <= START_OFFSET;
        end else begin
            if (start_o) begin
                busy_q <= 1'b1;
            end else if (done_i) begin
                busy_q <= 1'b0;
            end

            case (state_q)
                SEQ_BOOT: begin
                    if (boot_cnt_q == 5'(BOOT_DELAY - 1)) begin
                        state_q <= SEQ_WR_SCALE;
                    end else begin
                        boot_cnt_q <= boot_cnt_q + 5'd1;
                    end
                end
                SEQ_WR_SCALE:  if (done_i) state_q <= SEQ_WR_OFFSET;
                SEQ_WR_OFFSET: if (done_i) state_q <= SEQ_LOAD;
                SEQ_LOAD:      if (done_i) state_q <= SEQ_APPLY;
                SEQ_APPLY: begin
                    if (done_i) begin
                        info_q[WORD_SCALE]  <= scale_word;  // Now in effect downstream
                        info_q[WORD_OFFSET] <= offset_word;
                        state_q             <= SEQ_RESET;
                    end
                end
                SEQ_RESET: if (done_i) state_q <= SEQ_START;
                SEQ_START: if (done_i) state_q <= SEQ_POLL;
                SEQ_POLL: begin
                    // Not done yet, the next poll goes out after busy clears
                    if (done_i && rdata_i[STATUS_DONE_BIT]) begin
                        read_idx_q <= '0;
                        state_q    <= SEQ_READ;
                    end
                end
                SEQ_READ: begin
                    if (calc_step) begin
                        scale_q  <= next_scale_i;
                        offset_q <= next_offset_i;
                        state_q  <= SEQ_WR_SCALE;
                    end else if (done_i) begin
                        info_q[read_idx_q] <= rdata_i;
                        read_idx_q         <= read_idx_q + 3'd1;
                    end
                end
                default: state_q <= SEQ_BOOT;
            endcase
        end
    end

    assign info_o = agc_info_s'(info_q);

endmodule

`default_nettype wire

/* design/agc_status_target.sv */
`default_nettype none

module agc_status_target (
    input  logic                    wb_clk_i,
    input  logic                    rst_i,
    input  agc_loop_pkg::wb_req_s   req_i,
    output agc_loop_pkg::wb_rsp_s   rsp_o,
    input  agc_loop_pkg::agc_info_s info_i
);
    import agc_loop_pkg::*;

    tgt_state_e  state_q;
    wb_data_t    resp_q;
    info_words_t words;
    logic [3:0]  word_idx;

    assign words    = info_words_t'(info_i);
    assign word_idx = req_i.adr[5:2];

    //////////////////////////////////////////////////
    // Host handshake, ack two cycles after the request

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            state_q <= TGT_IDLE;
        end else begin
            case (state_q)
                TGT_IDLE: begin
                    if (req_i.cyc && req_i.stb) begin
                        state_q <= req_i.we ? TGT_WRITE : TGT_READ;
                    end
                end
                TGT_WRITE: state_q <= TGT_ACK;  // Writes are ignored
                TGT_READ:  state_q <= TGT_ACK;
                default:   state_q <= TGT_IDLE;
            endcase
        end
    end

    // Bit 6 picks the loop step sizes over the status words
    always_ff @(posedge wb_clk_i) begin
        if (state_q == TGT_READ) begin
            if (req_i.adr[6]) begin
                case (word_idx)
                    4'd0:    resp_q <= {15'b0, SCALE_DELTA};
                    4'd1:    resp_q <= {{16{OFFSET_DELTA[15]}}, OFFSET_DELTA};
                    default: resp_q <= '0;
                endcase
            end else if (word_idx < 4'(INFO_WORDS)) begin
                resp_q <= words[word_idx[2:0]];
            end else begin
                resp_q <= '0;
            end
        end
    end

    assign rsp_o.ack = (state_q == TGT_ACK);
    assign rsp_o.dat = resp_q;

endmodule

`default_nettype wire

/* design/agc_loop_top.sv */
`default_nettype none

module agc_loop_top (
    input  logic                  wb_clk_i,
    input  logic                  rst_i,
    input  agc_loop_pkg::wb_req_s host_req_i,
    output agc_loop_pkg::wb_rsp_s host_rsp_o,
    output agc_loop_pkg::wb_req_s agc_req_o,
    input  agc_loop_pkg::wb_rsp_s agc_rsp_i
);
    import agc_loop_pkg::*;

    // Sequencer to bus master
    logic        xfer_start;
    wb_addr_t    xfer_adr;
    wb_data_t    xfer_dat;
    logic        xfer_we;
    logic        xfer_done;
    wb_data_t    xfer_rdata;

    // Status words and the next pass values
    agc_info_s   info;
    agc_scale_t  next_scale;
    agc_offset_t next_offset;

    agc_loop_sequencer agc_loop_sequencer_i (
        .wb_clk_i      (wb_clk_i),
        .rst_i         (rst_i),
        .start_o       (xfer_start),
        .adr_o         (xfer_adr),
        .dat_o         (xfer_dat),
        .we_o          (xfer_we),
        .done_i        (xfer_done),
        .rdata_i       (xfer_rdata),
        .next_scale_i  (next_scale),
        .next_offset_i (next_offset),
        .info_o        (info)
    );

    agc_bus_master agc_bus_master_i (
        .wb_clk_i (wb_clk_i),
        .rst_i    (rst_i),
        .start_i  (xfer_start),
        .adr_i    (xfer_adr),
        .dat_i    (xfer_dat),
        .we_i     (xfer_we),
        .done_o   (xfer_done),
        .rdata_o  (xfer_rdata),
        .req_o    (agc_req_o),
        .rsp_i    (agc_rsp_i)
    );

    agc_gain_calc agc_gain_calc_i (
        .info_i   (info),
        .scale_o  (next_scale),
        .offset_o (next_offset)
    );

    agc_status_target agc_status_target_i (
        .wb_clk_i (wb_clk_i),
        .rst_i    (rst_i),
        .req_i    (host_req_i),
        .rsp_o    (host_rsp_o),
        .info_i   (info)
    );

endmodule

`default_nettype wire

/* tests/agc_model.sv */
`default_nettype none

module agc_model (
    input  logic                  wb_clk_i,
    input  logic                  rst_i,
    input  agc_loop_pkg::wb_req_s req_i,
    output agc_loop_pkg::wb_rsp_s rsp_o,
    output logic                  log_valid_o,   // One cycle per finished transfer
    output agc_loop_pkg::wb_req_s log_o          // Dat holds write or read data
);
    import agc_loop_pkg::*;

    logic        ack_q = 1'b0;
    wb_data_t    rdat_q = '0;
    logic [15:0] lfsr_q = 16'd55;
    logic        active = 1'b0;
    logic [1:0]  wait_left;
    int          polls;
    int          pass_cnt;
    wb_data_t    scale_w;
    wb_data_t    offset_w;
    wb_data_t    ms_w;
    wb_data_t    over_w;
    wb_data_t    under_w;
    wb_data_t    rdata;
    logic [15:0] r;

    initial begin
        log_valid_o = 1'b0;
        log_o       = '0;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [15:0] bits);
        int i;
        bits = '0;
        for (i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            bits   = {bits[14:0], lfsr_q[0]};
        end
    endtask

    //////////////////////////////////////////////////
    // Measurements for one pass

    task automatic new_measurements();
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] lo;
        wb_data_t    level;
        take_bits(13, lo);
        case (pass_cnt % 3)
            0: begin
                take_bits(3, a);
                level = 32'(a) + 32'd17;   // Above the target
            end
            1: begin
                take_bits(4, a);
                level = 32'(a);            // Below, 0 to 15
            end
            default: level = 32'd16;
        endcase
        ms_w = (level << (17 - TIMESCALE_RED_BITS)) | 32'(lo[12:0]);
        take_bits(4, a);
        take_bits(2, b);
        case (pass_cnt % 4)
            0: begin
                over_w  = 32'(a) + 32'd10;  // Clearly more over than under
                under_w = 32'(b);
            end
            1: begin
                over_w  = 32'(b);
                under_w = 32'(a) + 32'd10;
            end
            2: begin
                under_w = 32'(a);
                over_w  = 32'(a) + 32'd5;   // Right on the margin
            end
            default: begin
                take_bits(4, b);
                over_w  = 32'(a);
                under_w = 32'(b);
            end
        endcase
    endtask

    //////////////////////////////////////////////////
    // Register block with random ack delay

    always @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_q       <= 1'b0;
            log_valid_o <= 1'b0;
            active      = 1'b0;
            wait_left   = '0;
            lfsr_q      = 16'd55;
            polls       = 0;
            pass_cnt    = 0;
            scale_w     = '0;
            offset_w    = '0;
            ms_w        = '0;
            over_w      = '0;
            under_w     = '0;
        end else begin
            ack_q       <= 1'b0;
            log_valid_o <= 1'b0;
            if (req_i.cyc && req_i.stb && !ack_q) begin
                if (!active) begin
                    active = 1'b1;
                    take_bits(2, r);
                    wait_left = r[1:0];    // Ack after 1 to 4 cycles
                end
                if (wait_left != 2'd0) begin
                    wait_left = wait_left - 2'd1;
                end else begin
                    active = 1'b0;
                    rdata  = '0;
                    if (req_i.we) begin
                        rdata = req_i.dat;
                        if (req_i.adr == ADDR_SCALE) begin
                            scale_w = req_i.dat;
                        end else if (req_i.adr == ADDR_OFFSET) begin
                            offset_w = req_i.dat;
                        end else if (req_i.adr == ADDR_CTRL && req_i.dat == CMD_START) begin
                            polls = 0;
                            new_measurements();
                        end
                    end else begin
                        case (req_i.adr)
                            8'h00: begin
                                polls++;
                                if (polls >= 3) begin
                                    rdata = 32'd1 << STATUS_DONE_BIT;
                                end
                            end
                            8'h04: rdata = ms_w;
                            8'h08: rdata = over_w;
                            8'h0C: rdata = under_w;
                            8'h10: begin
                                // Two passes report a scale pinned at a cutoff
                                if (pass_cnt == 3) begin
                                    rdata = 32'(SCALE_MIN);
                                end else if (pass_cnt == 7) begin
                                    rdata = 32'(SCALE_MAX);
                                end else begin
                                    rdata = scale_w;
                                end
                            end
                            8'h14: begin
                                rdata = offset_w;
                                pass_cnt++;        // Last word of the pass
                            end
                            default: rdata = '0;
                        endcase
                    end
                    ack_q       <= 1'b1;
                    rdat_q      <= rdata;
                    log_valid_o <= 1'b1;
                    log_o.we    <= req_i.we;
                    log_o.adr   <= req_i.adr;
                    log_o.dat   <= rdata;
                end
            end
        end
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = rdat_q;

endmodule

`default_nettype wire

/* tests/agc_loop_tb.sv */
`default_nettype none

module agc_loop_tb;
    import agc_loop_pkg::*;

    localparam int PASSES         = 12;
    localparam int TIMEOUT        = 200;    // Cycles per bus wait
    localparam int WINDOW_TIMEOUT = 1000;

    logic     wb_clk_i;
    logic     rst_i;
    wb_req_s  host_req;
    wb_rsp_s  host_rsp;
    wb_req_s  agc_req;
    wb_rsp_s  agc_rsp;
    logic     log_valid;
    wb_req_s  log_x;

    int       checks = 0;
    int       errors = 0;
    int       windows_q = 0;   // Bumped when the status words are stable for the host
    logic     host_done = 1'b0;
    wb_data_t host_exp [INFO_WORDS];

    agc_loop_top agc_loop_top_i (
        .wb_clk_i   (wb_clk_i),
        .rst_i      (rst_i),
        .host_req_i (host_req),
        .host_rsp_o (host_rsp),
        .agc_req_o  (agc_req),
        .agc_rsp_i  (agc_rsp)
    );

    agc_model agc_model_i (
        .wb_clk_i    (wb_clk_i),
        .rst_i       (rst_i),
        .req_i       (agc_req),
        .rsp_o       (agc_rsp),
        .log_valid_o (log_valid),
        .log_o       (log_x)
    );

    initial begin
        wb_clk_i = 1'b0;
        forever #50 wb_clk_i = ~wb_clk_i;
    end

    initial begin
        rst_i    = 1'b1;
        host_req = '0;
        repeat (8) @(posedge wb_clk_i);
        rst_i <= 1'b0;
    end

    //////////////////////////////////////////////////
    // Expected next scale and offset from six status words

    function automatic logic [32:0] ref_next(input agc_info_s w);
        logic [31:0] ms;
        logic [16:0] s;
        logic [15:0] o;
        ms = w.ms >> (17 - TIMESCALE_RED_BITS);
        s  = w.scale[16:0];
        o  = w.offset[15:0];
        if (ms > TARGET_RMS_SQ + RMS_SQ_ERR) begin
            if (s > SCALE_MIN) begin
                s = s - SCALE_DELTA;
            end
        end else if (ms < TARGET_RMS_SQ - RMS_SQ_ERR) begin
            if (s < SCALE_MAX) begin
                s = s + SCALE_DELTA;
            end
        end
        if (longint'(w.over_cnt) > longint'(w.under_cnt) + OFFSET_ERR) begin
            o = o - OFFSET_DELTA;          // Wraps at 16 bits
        end else if (longint'(w.under_cnt) > longint'(w.over_cnt) + OFFSET_ERR) begin
            o = o + OFFSET_DELTA;
        end
        return {s, o};
    endfunction

    task automatic check_value(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("[FAIL] %0t: %s", $time, what);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        errors++;
        $display("Timeout: %s", what);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Regression failed");
        $finish;
    endtask

    task automatic next_xfer(output wb_req_s x);
        int waited;
        waited = 0;
        @(posedge wb_clk_i);
        while (!log_valid && waited < TIMEOUT) begin
            @(posedge wb_clk_i);
            waited++;
        end
        if (!log_valid) begin
            stop_on_timeout("no downstream transfer completed");
        end else begin
            x = log_x;
        end
    endtask

    task automatic expect_write(input wb_addr_t adr, input wb_data_t dat);
        wb_req_s x;
        next_xfer(x);
        check_value(x.we && x.adr == adr && x.dat == dat,
            $sformatf("write %h to %h expected, got we=%b adr=%h dat=%h",
                      dat, adr, x.we, x.adr, x.dat));
    endtask

    task automatic host_xfer(input logic we, input wb_addr_t adr, input wb_data_t dat,
                             output wb_data_t rdata);
        wb_req_s r;
        int      waited;
        r.cyc    = 1'b1;
        r.stb    = 1'b1;
        r.we     = we;
        r.adr    = adr;
        r.dat    = dat;
        host_req <= r;
        @(posedge wb_clk_i);
        waited = 1;
        while (!host_rsp.ack && waited < TIMEOUT) begin
            @(posedge wb_clk_i);
            waited++;
        end
        if (!host_rsp.ack) begin
            stop_on_timeout("host transfer was never acked");
        end else begin
            // Ack is up in the second cycle after the request
            check_value(waited == 3, $sformatf("host ack at %h after %0d edges", adr, waited));
            rdata = host_rsp.dat;
        end
    endtask

    //////////////////////////////////////////////////
    // Downstream checker

    initial begin : compare
        wb_req_s     x;
        info_words_t got;
        agc_scale_t  exp_scale;
        agc_offset_t exp_offset;
        logic [32:0] nxt;
        int          waited;
        int          cov [7];      // Scale dec, inc, cutoff, band; offset dec, inc, hold
        exp_scale  = 17'd1800;
        exp_offset = 16'sd0;
        got        = '0;
        cov        = '{default: 0};
        waited     = 0;
        @(posedge wb_clk_i);
        while (rst_i && waited < TIMEOUT) begin
            @(posedge wb_clk_i);
            waited++;
        end
        repeat (BOOT_DELAY) begin
            @(posedge wb_clk_i);
            check_value(!agc_req.cyc, "bus cycle started during the boot delay");
        end
        for (int p = 0; p < PASSES; p++) begin
            expect_write(ADDR_SCALE, {15'b0, exp_scale});
            expect_write(ADDR_OFFSET, {{16{exp_offset[15]}}, exp_offset});
            expect_write(ADDR_CTRL, 32'h300);
            expect_write(ADDR_CTRL, 32'h400);
            expect_write(ADDR_CTRL, 32'h004);
            expect_write(ADDR_CTRL, 32'h001);
            for (int i = 0; i < 4; i++) begin
                host_exp[i] = got[i];
            end
            host_exp[4] = {15'b0, exp_scale};
            host_exp[5] = {{16{exp_offset[15]}}, exp_offset};
            windows_q++;
            for (int k = 1; k <= 3; k++) begin
                next_xfer(x);
                check_value(!x.we && x.adr == ADDR_CTRL && x.dat[STATUS_DONE_BIT] == (k == 3),
                    $sformatf("poll %0d got we=%b adr=%h dat=%h", k, x.we, x.adr, x.dat));
            end
            for (int w = 0; w < INFO_WORDS; w++) begin
                next_xfer(x);
                check_value(!x.we && x.adr == 8'(4 * w),
                    $sformatf("status read %0d got we=%b adr=%h", w, x.we, x.adr));
                got[w] = x.dat;
            end
            nxt        = ref_next(agc_info_s'(got));
            exp_scale  = nxt[32:16];
            exp_offset = nxt[15:0];
            if (exp_scale < got[4][16:0]) begin
                cov[0]++;
            end else if (exp_scale > got[4][16:0]) begin
                cov[1]++;
            end else if ((got[1] >> (17 - TIMESCALE_RED_BITS)) != 32'd16) begin
                cov[2]++;                  // Held although out of band
            end else begin
                cov[3]++;
            end
            if (exp_offset != got[5][15:0]) begin
                cov[($signed(exp_offset) < $signed(got[5][15:0])) ? 4 : 5]++;
            end else begin
                cov[6]++;
            end
        end
        expect_write(ADDR_SCALE, {15'b0, exp_scale});
        expect_write(ADDR_OFFSET, {{16{exp_offset[15]}}, exp_offset});
        for (int c = 0; c < 7; c++) begin
            check_value(cov[c] > 0, $sformatf("update case %0d was never exercised", c));
        end
        waited = 0;
        while (!host_done && waited < WINDOW_TIMEOUT) begin
            @(posedge wb_clk_i);
            waited++;
        end
        if (!host_done) begin
            stop_on_timeout("host reads did not finish");
        end else begin
            $display("Checks: %0d, errors: %0d", checks, errors);
            if (errors == 0) begin
                $display("Regression passed");
            end else begin
                $display("Regression failed");
            end
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Host reads while the loop polls

    initial begin : host
        wb_data_t rd;
        int       seen;
        int       waited;
        int       w;
        seen = 0;
        for (int p = 0; p < PASSES; p++) begin
            waited = 0;
            while (windows_q == seen && waited < WINDOW_TIMEOUT) begin
                @(posedge wb_clk_i);
                waited++;
            end
            if (windows_q == seen) begin
                stop_on_timeout("no quiet window for host reads");
            end else begin
                seen = windows_q;
                w    = p % INFO_WORDS;
                if (p == 2) begin
                    host_xfer(1'b1, 8'h08, 32'hA5A5_0F0F, rd);  // Must leave word 2 alone
                end
                host_xfer(1'b0, (p % 2) ? 8'h44 : 8'h40, '0, rd);
                check_value(rd == ((p % 2) ? 32'd25 : 32'd30),
                    $sformatf("step size read got %0d", rd));
                host_xfer(1'b0, 8'(4 * w), '0, rd);
                check_value(rd == host_exp[w],
                    $sformatf("word %0d read %h, expected %h", w, rd, host_exp[w]));
                w = (w + 3) % INFO_WORDS;
                host_xfer(1'b0, 8'(4 * w), '0, rd);
                check_value(rd == host_exp[w],
                    $sformatf("word %0d read %h, expected %h", w, rd, host_exp[w]));
                host_req <= '0;
            end
        end
        host_done = 1'b1;
    end

endmodule

`default_nettype wire

/* filelist.f */
design/agc_loop_pkg.sv
design/agc_bus_master.sv
design/agc_gain_calc.sv
design/agc_loop_sequencer.sv
design/agc_status_target.sv
design/agc_loop_top.sv
tests/agc_model.sv
tests/agc_loop_tb.sv

/* Bender.yml */
package:
  name: agc_loop

sources:
  - files:
      - design/agc_loop_pkg.sv
      - design/agc_bus_master.sv
      - design/agc_gain_calc.sv
      - design/agc_loop_sequencer.sv
      - design/agc_status_target.sv
      - design/agc_loop_top.sv
  - target: test
    files:
      - tests/agc_model.sv
      - tests/agc_loop_tb.sv
